// ==== compile.f ====
+incdir+hw
hw/board_pkg.sv
hw/board_rst_sync.sv
hw/rtc_clk_div.sv
hw/fan_pwm_ctrl.sv
hw/sd_spi_pad_map.sv
hw/board_glue_top.sv
verification/board_glue_tb.sv

// ==== hw/board_defines.svh ====
// Board glue constants
// Divider ratios, PWM timing and reset synchronizer depth for the
// logic between the board pins and the SoC core

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// RTC divider, 50 MHz soc_clk down to 1 MHz
`define BOARD_RTC_HALF_DIV 25
`define BOARD_RTC_CNT_W 5

// Fan PWM, prescaler cycles per step and steps per period
`define BOARD_FAN_PRESCALE 4
`define BOARD_FAN_STEPS 16

// Flops in the reset release chain
`define BOARD_RST_STAGES 2

`endif

// ==== hw/board_glue_top.sv ====
// Board glue top level
// Sits between the board pins and the SoC core. Holds the reset
// synchronizer, the RTC divider, the fan PWM and the SD card pad mapper

`timescale 1ns/1ps

module board_glue_top (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  logic                   test_mode_i,
  input  board_pkg::fan_level_t  fan_sw_i,
  input  logic                   spi_sck_i,
  input  logic                   spi_sck_en_i,
  input  board_pkg::spi_cs_t     spi_cs_i,
  input  logic                   spi_cs_en_i,
  input  board_pkg::spi_sd_t     spi_sd_i,
  input  logic                   spi_sd_en_i,
  input  logic                   sd_dat0_i,
  output logic                   soc_rst_no,
  output logic                   rtc_o,
  output logic                   fan_pwm_o,
  output logic                   sd_sclk_o,
  output logic                   sd_cmd_o,
  output logic                   sd_dat3_o,
  output logic [1:0]             sd_dat12_o,
  output logic                   sd_reset_o,
  output board_pkg::spi_sd_t     spi_sd_o
);

  // Synchronized reset for everything on soc_clk
  logic soc_rst_n;

  assign soc_rst_no = soc_rst_n;

  ////////////////////
  // Reset
  ////////////////////

  board_rst_sync i_rst_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_no  ( soc_rst_n   )
  );

  ////////////////////
  // RTC and fan
  ////////////////////

  rtc_clk_div i_rtc_clk_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  fan_pwm_ctrl i_fan_pwm_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////
  // SD card slot
  ////////////////////

  sd_spi_pad_map i_sd_pad_map (
    .spi_sck_i    ( spi_sck_i    ),
    .spi_sck_en_i ( spi_sck_en_i ),
    .spi_cs_i     ( spi_cs_i     ),
    .spi_cs_en_i  ( spi_cs_en_i  ),
    .spi_sd_i     ( spi_sd_i     ),
    .spi_sd_en_i  ( spi_sd_en_i  ),
    .sd_dat0_i    ( sd_dat0_i    ),
    .spi_sd_o     ( spi_sd_o     ),
    .sd_sclk_o    ( sd_sclk_o    ),
    .sd_cmd_o     ( sd_cmd_o     ),
    .sd_dat3_o    ( sd_dat3_o    ),
    .sd_dat12_o   ( sd_dat12_o   ),
    .sd_reset_o   ( sd_reset_o   )
  );

endmodule

// ==== hw/board_pkg.sv ====
// Board glue types
// Fan setting, counter and SPI pin group types shared by the
// board glue blocks and their testbench

`include "board_defines.svh"

package board_pkg;

  // Four board switches select the fan level
  typedef logic [3:0] fan_level_t;

  // RTC half-period counter
  typedef logic [`BOARD_RTC_CNT_W-1:0] rtc_cnt_t;

  // PWM step index within one period
  typedef logic [3:0] pwm_step_t;

  // SPI host chip selects and data lanes
  typedef logic [1:0] spi_cs_t;
  typedef logic [3:0] spi_sd_t;

endpackage

// ==== hw/board_rst_sync.sv ====
// Board reset synchronizer
// Asserts asynchronously with rst_n and releases after a short flop
// chain on soc_clk. Test mode hands the board reset straight through

`timescale 1ns/1ps
`include "board_defines.svh"

module board_rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic soc_rst_no
);

  logic [`BOARD_RST_STAGES-1:0] sync_q;

  // Ones shift in once the board reset is gone
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`BOARD_RST_STAGES-2:0], 1'b1};
    end
  end

  // Bypass for scan and test
  assign soc_rst_no = test_mode_i ? rst_n : sync_q[`BOARD_RST_STAGES-1];

  ////////////////////
  // Checks
  ////////////////////

  // No release before the board reset has been high through the whole chain
  a_no_early_release: assert property (
    @(posedge soc_clk) $rose(soc_rst_no) && !test_mode_i
      |-> $past(rst_n, `BOARD_RST_STAGES)
  );

endmodule

// ==== hw/fan_pwm_ctrl.sv ====
// Fan PWM controller
// Turns the 4-bit board switch setting into a PWM waveform. A period is
// BOARD_FAN_STEPS steps of BOARD_FAN_PRESCALE cycles; the output is high
// for the first (setting) steps. The setting is taken once per period

`timescale 1ns/1ps
`include "board_defines.svh"

module fan_pwm_ctrl (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  board_pkg::fan_level_t  fan_sw_i,
  output logic                   fan_pwm_o
);

  import board_pkg::*;

  localparam int unsigned presc_w = $clog2(`BOARD_FAN_PRESCALE);

  localparam logic [presc_w-1:0] presc_last = presc_w'(`BOARD_FAN_PRESCALE - 1);
  localparam pwm_step_t step_last = pwm_step_t'(`BOARD_FAN_STEPS - 1);

  logic [presc_w-1:0] presc_q;
  pwm_step_t          step_q;
  fan_level_t         level_q;
  logic               step_adv;
  logic               period_end;

  assign step_adv   = (presc_q == presc_last);
  assign period_end = step_adv && (step_q == step_last);

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
    end else begin
      presc_q <= step_adv ? '0 : presc_q + 1'b1;
      if (period_end) begin
        step_q <= '0;
      end else if (step_adv) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // Setting is loaded as the counter enters step 0
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
    end else if (period_end) begin
      level_q <= fan_sw_i;
    end
  end

  // High while the step is below the latched setting
  assign fan_pwm_o = (step_q < level_q);

  // The fan switches on only as a new period starts
  a_on_at_period_start: assert property (
    @(posedge soc_clk) disable iff (!rst_n) $rose(fan_pwm_o) |-> (step_q == '0)
  );

endmodule

// ==== hw/rtc_clk_div.sv ====
// RTC clock divider
// Makes the slow real-time-clock square wave for the SoC by
// toggling a flop every BOARD_RTC_HALF_DIV soc_clk cycles

`timescale 1ns/1ps
`include "board_defines.svh"

module rtc_clk_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  localparam rtc_cnt_t wrap_val = rtc_cnt_t'(`BOARD_RTC_HALF_DIV - 1);

  rtc_cnt_t cnt_q;
  logic     rtc_q;
  logic     wrap;

  assign wrap = (cnt_q == wrap_val);

  // Half period counter, the output flips on every wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q <= '0;
        rtc_q <= ~rtc_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign rtc_o = rtc_q;

  ////////////////////
  // Checks
  ////////////////////

  // Counter stays inside its half period
  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n) cnt_q <= wrap_val
  );

endmodule

// ==== hw/sd_spi_pad_map.sv ====
// SD card pad mapper
// Puts the SPI host pins onto the SD card slot in SPI mode.
// Disabled host outputs leave their card pin idling high

`timescale 1ns/1ps

module sd_spi_pad_map (
  input  logic               spi_sck_i,
  input  logic               spi_sck_en_i,
  input  board_pkg::spi_cs_t spi_cs_i,
  input  logic               spi_cs_en_i,
  input  board_pkg::spi_sd_t spi_sd_i,
  input  logic               spi_sd_en_i,
  input  logic               sd_dat0_i,
  output board_pkg::spi_sd_t spi_sd_o,
  output logic               sd_sclk_o,
  output logic               sd_cmd_o,
  output logic               sd_dat3_o,
  output logic [1:0]         sd_dat12_o,
  output logic               sd_reset_o
);

  // Reset pin low keeps the card powered
  assign sd_reset_o = 1'b0;

  // SCK onto the card clock
  assign sd_sclk_o = spi_sck_en_i ? spi_sck_i : 1'b1;

  // Chip select 0 onto DAT3
  assign sd_dat3_o = spi_cs_en_i ? spi_cs_i[0] : 1'b1;

  // MOSI onto CMD
  assign sd_cmd_o = spi_sd_en_i ? spi_sd_i[0] : 1'b1;

  // DAT1 and DAT2 are unused in SPI mode
  assign sd_dat12_o = 2'b11;

  // MISO comes back from DAT0 on lane 1, rest read zero
  assign spi_sd_o = {2'b00, sd_dat0_i, 1'b0};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the board glue simulation with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module board_glue_tb -o board_glue_sim \
  && ./obj_dir/board_glue_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// ==== verification/board_glue_tb.sv ====
// Board glue testbench
// Drives reset, test mode, fan switches and random SPI pins into the
// board glue top level. Reference counters built from the timing rules
// feed concurrent assertions that compare the outputs every cycle

`timescale 1ns/1ps
`include "board_defines.svh"

module board_glue_tb;

  import board_pkg::*;

  localparam int rtc_period = 2 * `BOARD_RTC_HALF_DIV;
  localparam int fan_period = `BOARD_FAN_PRESCALE * `BOARD_FAN_STEPS;

  // Phase lengths in cycles
  localparam int rst_cyc = 40;
  localparam int rtc_cyc = 3 * rtc_period;
  localparam int fan_cyc = 4 * 3 * fan_period;
  localparam int spi_cyc = 42;
  localparam int limit_cyc = 2 * (rst_cyc + rtc_cyc + fan_cyc + spi_cyc);

  logic       soc_clk;
  logic       rst_n;
  logic       test_mode;
  fan_level_t fan_sw;
  logic       spi_sck;
  logic       spi_sck_en;
  spi_cs_t    spi_cs;
  logic       spi_cs_en;
  spi_sd_t    spi_sd;
  logic       spi_sd_en;
  logic       sd_dat0;
  logic       soc_rst_n;
  logic       rtc;
  logic       fan_pwm;
  logic       sd_sclk;
  logic       sd_cmd;
  logic       sd_dat3;
  logic [1:0] sd_dat12;
  logic       sd_reset;
  spi_sd_t    spi_sd_ret;

  int          err_cnt = 0;
  int          cyc = 0;
  int          hi_edges = 0;
  int          rtc_edges = 0;
  int          fan_edges = 0;
  int          fan_lvl = 0;
  int          hi_acc = 0;
  int          period_hi = 0;
  int          period_lvl = 0;
  logic        period_done = 1'b0;
  logic [31:0] lfsr = 32'd77856;

  board_glue_top DUT (
    .soc_clk      ( soc_clk    ),
    .rst_n        ( rst_n      ),
    .test_mode_i  ( test_mode  ),
    .fan_sw_i     ( fan_sw     ),
    .spi_sck_i    ( spi_sck    ),
    .spi_sck_en_i ( spi_sck_en ),
    .spi_cs_i     ( spi_cs     ),
    .spi_cs_en_i  ( spi_cs_en  ),
    .spi_sd_i     ( spi_sd     ),
    .spi_sd_en_i  ( spi_sd_en  ),
    .sd_dat0_i    ( sd_dat0    ),
    .soc_rst_no   ( soc_rst_n  ),
    .rtc_o        ( rtc        ),
    .fan_pwm_o    ( fan_pwm    ),
    .sd_sclk_o    ( sd_sclk    ),
    .sd_cmd_o     ( sd_cmd     ),
    .sd_dat3_o    ( sd_dat3    ),
    .sd_dat12_o   ( sd_dat12   ),
    .sd_reset_o   ( sd_reset   ),
    .spi_sd_o     ( spi_sd_ret )
  );

  initial soc_clk = 1'b0;
  always #10 soc_clk = ~soc_clk;

  ////////////////////
  // Reference model
  ////////////////////

  logic    rst_exp;
  logic    rtc_exp;
  logic    pwm_exp;
  logic    sclk_exp;
  logic    cmd_exp;
  logic    dat3_exp;
  spi_sd_t miso_exp;

  // Release after two edges with rst_n high, bypass in test mode
  assign rst_exp  = test_mode ? rst_n : (rst_n && hi_edges >= `BOARD_RST_STAGES);
  assign rtc_exp  = rst_exp && (rtc_edges >= `BOARD_RTC_HALF_DIV);
  assign pwm_exp  = rst_exp && (fan_edges < `BOARD_FAN_PRESCALE * fan_lvl);
  assign sclk_exp = spi_sck_en ? spi_sck : 1'b1;
  assign cmd_exp  = spi_sd_en ? spi_sd[0] : 1'b1;
  assign dat3_exp = spi_cs_en ? spi_cs[0] : 1'b1;
  // Card DAT0 lands on lane 1, every other lane is zero
  assign miso_exp = spi_sd_t'(sd_dat0) << 1;

  always @(posedge soc_clk) begin
    hi_edges <= !rst_n ? 0 : ((hi_edges < `BOARD_RST_STAGES) ? hi_edges + 1 : hi_edges);
    if (!rst_exp) begin
      rtc_edges   <= 0;
      fan_edges   <= 0;
      fan_lvl     <= 0;
      hi_acc      <= 0;
      period_done <= 1'b0;
    end else begin
      rtc_edges   <= (rtc_edges == rtc_period - 1) ? 0 : rtc_edges + 1;
      fan_edges   <= (fan_edges == fan_period - 1) ? 0 : fan_edges + 1;
      hi_acc      <= (fan_edges == fan_period - 1) ? 0 : hi_acc + (fan_pwm ? 1 : 0);
      period_done <= (fan_edges == fan_period - 1);
      // Switches are taken as a new period begins
      if (fan_edges == fan_period - 1) begin
        fan_lvl    <= int'(fan_sw);
        period_hi  <= hi_acc + (fan_pwm ? 1 : 0);
        period_lvl <= fan_lvl;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_mismatch(input string name, input int exp, input int got);
    err_cnt++;
    $display("mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
  endtask

  a_soc_rst: assert property (@(posedge soc_clk) soc_rst_n == rst_exp)
    else report_mismatch("soc_rst_no", int'($sampled(rst_exp)), int'($sampled(soc_rst_n)));
  a_rtc: assert property (@(posedge soc_clk) rtc == rtc_exp)
    else report_mismatch("rtc_o", int'($sampled(rtc_exp)), int'($sampled(rtc)));
  a_fan: assert property (@(posedge soc_clk) fan_pwm == pwm_exp)
    else report_mismatch("fan_pwm_o", int'($sampled(pwm_exp)), int'($sampled(fan_pwm)));
  a_fan_period: assert property (
    @(posedge soc_clk) period_done |-> period_hi == `BOARD_FAN_PRESCALE * period_lvl
  ) else report_mismatch("fan_pwm_o high cycles",
                         `BOARD_FAN_PRESCALE * $sampled(period_lvl), $sampled(period_hi));
  a_sclk: assert property (@(posedge soc_clk) sd_sclk == sclk_exp)
    else report_mismatch("sd_sclk_o", int'($sampled(sclk_exp)), int'($sampled(sd_sclk)));
  a_cmd: assert property (@(posedge soc_clk) sd_cmd == cmd_exp)
    else report_mismatch("sd_cmd_o", int'($sampled(cmd_exp)), int'($sampled(sd_cmd)));
  a_dat3: assert property (@(posedge soc_clk) sd_dat3 == dat3_exp)
    else report_mismatch("sd_dat3_o", int'($sampled(dat3_exp)), int'($sampled(sd_dat3)));
  a_dat12: assert property (@(posedge soc_clk) sd_dat12 == 2'b11)
    else report_mismatch("sd_dat12_o", 3, int'($sampled(sd_dat12)));
  a_sd_reset: assert property (@(posedge soc_clk) !sd_reset)
    else report_mismatch("sd_reset_o", 0, int'($sampled(sd_reset)));
  a_miso: assert property (@(posedge soc_clk) spi_sd_ret == miso_exp)
    else report_mismatch("spi_sd_o", int'($sampled(miso_exp)), int'($sampled(spi_sd_ret)));

  // Run limit
  always @(posedge soc_clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit_cyc) begin
      $display("Timeout, the run did not finish within %0d cycles", limit_cyc);
      $display("Errors counted: %0d", err_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(output logic [10:0] v);
    for (int b = 0; b < 11; b++) begin
      lfsr = lfsr_step(lfsr);
      v[b] = lfsr[0];
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge soc_clk);
  endtask

  initial begin
    logic [10:0] bits;
    rst_n      = 1'b0;
    test_mode  = 1'b0;
    fan_sw     = '0;
    spi_sck    = 1'b0;
    spi_sck_en = 1'b0;
    spi_cs     = '0;
    spi_cs_en  = 1'b0;
    spi_sd     = '0;
    spi_sd_en  = 1'b0;
    sd_dat0    = 1'b0;
    wait_cycles(3);
    rst_n <= 1'b1;
    wait_cycles(8);
    // Bypass path, short reset pulse
    test_mode <= 1'b1;
    wait_cycles(2);
    rst_n <= 1'b0;
    wait_cycles(2);
    rst_n <= 1'b1;
    wait_cycles(3);
    test_mode <= 1'b0;
    // Fresh release for the RTC and fan phases
    rst_n <= 1'b0;
    wait_cycles(3);
    rst_n <= 1'b1;
    wait_cycles(rtc_cyc);
    for (int lvl = 0; lvl < 4; lvl++) begin
      fan_sw <= fan_level_t'(5 * lvl);
      wait_cycles(3 * fan_period);
    end
    // Random SPI host pins
    for (int n = 0; n < spi_cyc; n++) begin
      draw_bits(bits);
      @(posedge soc_clk);
      spi_sck    <= bits[0];
      spi_sck_en <= bits[1];
      spi_cs     <= bits[3:2];
      spi_cs_en  <= bits[4];
      spi_sd     <= bits[8:5];
      spi_sd_en  <= bits[9];
      sd_dat0    <= bits[10];
    end
    wait_cycles(2);
    $display("Errors counted: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
